/* include/mips_defines.svh */
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// Datapath and register file geometry
`define DATA_W   32 // Register and ALU word
`define REG_AW   5  // 32 architectural registers
`define SHAMT_W  5  // Shift amount field

////////////////////////////////////////////////////////////
// Opcodes, bits 31:26
////////////////////////////////////////////////////////////
`define OP_RTYPE 6'h00 // Operation in funct field
`define OP_ADDI  6'h08
`define OP_SLTI  6'h0A
`define OP_ANDI  6'h0C
`define OP_ORI   6'h0D
`define OP_XORI  6'h0E
`define OP_LUI   6'h0F

////////////////////////////////////////////////////////////
// R-type funct codes, bits 5:0
////////////////////////////////////////////////////////////
`define FN_SLL   6'h00
`define FN_SRL   6'h02
`define FN_ADD   6'h20
`define FN_SUB   6'h22
`define FN_AND   6'h24
`define FN_OR    6'h25
`define FN_XOR   6'h26
`define FN_NOR   6'h27
`define FN_SLT   6'h2A

`endif

/* design/mips_pkg.sv */
`include "mips_defines.svh"

package mips_pkg;

	////////////////////////////////////////////////////////////
	// Field types
	////////////////////////////////////////////////////////////
	typedef logic [5:0]            opcode_t;
	typedef logic [5:0]            funct_t;
	typedef logic [`SHAMT_W-1:0]   shamt_t;
	typedef logic [`REG_AW-1:0]    reg_addr_t; // Register number
	typedef logic [`DATA_W-1:0]    word_t;     // Register contents
	typedef logic [15:0]           imm_t;      // I-type immediate

	// R-type layout
	typedef struct packed {
		opcode_t   opcode; // Always OP_RTYPE here
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t rd;
		shamt_t    shamt;  // Only SLL and SRL look at it
		funct_t    funct;
	} r_fmt_t;

	// I-type layout, rt is the destination
	typedef struct packed {
		opcode_t   opcode;
		reg_addr_t rs;
		reg_addr_t rt;
		imm_t      imm;
	} i_fmt_t;

	// One instruction word, two views
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
	} instr_t;

	////////////////////////////////////////////////////////////
	// ALU operations
	////////////////////////////////////////////////////////////
	// R and I forms share a value when the math is the same
	typedef enum logic [3:0] {
		ALU_ADD, // ADD, ADDI
		ALU_SUB,
		ALU_AND, // AND, ANDI
		ALU_OR,  // OR, ORI
		ALU_XOR, // XOR, XORI
		ALU_NOR,
		ALU_SLT, // SLT, SLTI, signed compare
		ALU_SLL,
		ALU_SRL, // Logical, zero fill
		ALU_LUI  // Immediate already shifted by decoder
	} alu_op_t;

endpackage

/* design/mips_issue_if.sv */
`timescale 1ns/1ps

// One decoded instruction, decoder to execute
interface mips_issue_if;
	import mips_pkg::*;

	logic      valid;     // Single-cycle strobe
	alu_op_t   op;
	reg_addr_t rs;        // Operand A register
	reg_addr_t rt;        // Operand B register, also shift source
	reg_addr_t rd;        // Destination
	word_t     operand_b; // Immediate, LUI value or shift amount
	logic      use_imm;   // Take operand_b instead of rt value

	modport producer (
		output valid,
		output op,
		output rs,
		output rt,
		output rd,
		output operand_b,
		output use_imm
	);

	modport consumer (
		input valid,
		input op,
		input rs,
		input rt,
		input rd,
		input operand_b,
		input use_imm
	);

endinterface

/* design/instr_decoder.sv */
`timescale 1ns/1ps
`include "mips_defines.svh"

module instr_decoder (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             instr_valid, // Strobe, no back-pressure
	input  mips_pkg::instr_t instr,
	mips_issue_if.producer   issue
);
	import mips_pkg::*;

	logic      dec_ok;      // Word is supported
	alu_op_t   dec_op;
	reg_addr_t dec_rd;
	word_t     dec_b;
	logic      dec_use_imm;

	////////////////////////////////////////////////////////////
	// Decode
	////////////////////////////////////////////////////////////
	always_comb begin
		dec_ok      = 1'b1;
		dec_op      = ALU_ADD;
		dec_rd      = instr.i.rt; // I-type writes rt
		dec_b       = {{(`DATA_W-16){instr.i.imm[15]}}, instr.i.imm}; // Sign extend
		dec_use_imm = 1'b1;
		case (instr.r.opcode)
			`OP_RTYPE: begin
				dec_rd      = instr.r.rd;
				dec_use_imm = 1'b0; // rt value is operand B
				dec_b       = {{(`DATA_W-`SHAMT_W){1'b0}}, instr.r.shamt};
				case (instr.r.funct)
					`FN_ADD: dec_op = ALU_ADD;
					`FN_SUB: dec_op = ALU_SUB;
					`FN_AND: dec_op = ALU_AND;
					`FN_OR:  dec_op = ALU_OR;
					`FN_XOR: dec_op = ALU_XOR;
					`FN_NOR: dec_op = ALU_NOR;
					`FN_SLT: dec_op = ALU_SLT;
					`FN_SLL: dec_op = ALU_SLL; // Shift amount rides in dec_b
					`FN_SRL: dec_op = ALU_SRL;
					default: dec_ok = 1'b0;   // Unknown funct, drop
				endcase
			end
			`OP_ADDI: dec_op = ALU_ADD; // Wraps, no trap
			`OP_SLTI: dec_op = ALU_SLT;
			// Logic immediates are zero extended
			`OP_ANDI: begin
				dec_op = ALU_AND;
				dec_b  = {{(`DATA_W-16){1'b0}}, instr.i.imm};
			end
			`OP_ORI: begin
				dec_op = ALU_OR;
				dec_b  = {{(`DATA_W-16){1'b0}}, instr.i.imm};
			end
			`OP_XORI: begin
				dec_op = ALU_XOR;
				dec_b  = {{(`DATA_W-16){1'b0}}, instr.i.imm};
			end
			`OP_LUI: begin
				dec_op = ALU_LUI;
				dec_b  = {instr.i.imm, {(`DATA_W-16){1'b0}}}; // Upper half
			end
			default: dec_ok = 1'b0; // Loads, branches etc. not handled
		endcase
	end

	////////////////////////////////////////////////////////////
	// Issue register
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n)
			issue.valid <= 1'b0;
		else
			issue.valid <= instr_valid && dec_ok; // One cycle after sample
	end

	// Payload only, held when idle
	always_ff @(posedge clk) begin
		if (instr_valid) begin
			issue.op        <= dec_op;
			issue.rs        <= instr.r.rs; // Same bits in both views
			issue.rt        <= instr.r.rt;
			issue.rd        <= dec_rd;
			issue.operand_b <= dec_b;
			issue.use_imm   <= dec_use_imm;
		end
	end

endmodule

/* design/register_file.sv */
`timescale 1ns/1ps
`include "mips_defines.svh"

module register_file (
	input  logic                clk,
	input  logic                rst_n,
	input  mips_pkg::reg_addr_t rd_addr_a,
	input  mips_pkg::reg_addr_t rd_addr_b,
	input  mips_pkg::reg_addr_t dbg_addr,  // Debug view of any register
	output mips_pkg::word_t     rd_data_a,
	output mips_pkg::word_t     rd_data_b,
	output mips_pkg::word_t     dbg_data,
	input  logic                wr_en,
	input  mips_pkg::reg_addr_t wr_addr,
	input  mips_pkg::word_t     wr_data
);
	import mips_pkg::*;

	word_t regs [2**`REG_AW]; // Architectural state

	// Register 0 is hardwired to zero on every port
	function automatic word_t read_reg(input reg_addr_t addr);
		word_t val;
		if (addr == '0)
			val = '0;
		else
			val = regs[addr];
		return val;
	endfunction

	////////////////////////////////////////////////////////////
	// Write port
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 2**`REG_AW; i++)
				regs[i] <= '0; // Whole file cleared
		end else if (wr_en && (wr_addr != '0)) begin
			regs[wr_addr] <= wr_data; // Visible to reads next cycle
		end
	end

	////////////////////////////////////////////////////////////
	// Read ports, all combinational
	////////////////////////////////////////////////////////////
	always_comb begin
		rd_data_a = read_reg(rd_addr_a);
		rd_data_b = read_reg(rd_addr_b);
		dbg_data  = read_reg(dbg_addr); // Not in the execute path
	end

endmodule

/* design/alu_execute.sv */
`timescale 1ns/1ps
`include "mips_defines.svh"

module alu_execute (
	input  logic                clk,
	input  logic                rst_n,
	mips_issue_if.consumer      issue,
	output mips_pkg::reg_addr_t rd_addr_a,
	output mips_pkg::reg_addr_t rd_addr_b,
	input  mips_pkg::word_t     rd_data_a,
	input  mips_pkg::word_t     rd_data_b,
	output logic                wr_en,
	output mips_pkg::reg_addr_t wr_addr,
	output mips_pkg::word_t     wr_data,
	output logic                res_valid,
	output mips_pkg::reg_addr_t res_dest,
	output mips_pkg::word_t     res_data
);
	import mips_pkg::*;

	word_t                op_a;   // rs value
	word_t                op_b;   // rt value or immediate
	logic [`SHAMT_W-1:0]  shamt;
	word_t                result;
	logic                 lt;     // Signed less-than

	////////////////////////////////////////////////////////////
	// Operand fetch
	////////////////////////////////////////////////////////////
	assign rd_addr_a = issue.rs;
	assign rd_addr_b = issue.rt;

	assign op_a  = rd_data_a;
	assign op_b  = issue.use_imm ? issue.operand_b : rd_data_b;
	assign shamt = issue.operand_b[`SHAMT_W-1:0]; // Low bits only

	assign lt = $signed(op_a) < $signed(op_b);

	////////////////////////////////////////////////////////////
	// ALU
	////////////////////////////////////////////////////////////
	always_comb begin
		case (issue.op)
			ALU_ADD: result = op_a + op_b; // Wraps on overflow
			ALU_SUB: result = op_a - op_b;
			ALU_AND: result = op_a & op_b;
			ALU_OR:  result = op_a | op_b;
			ALU_XOR: result = op_a ^ op_b;
			ALU_NOR: result = ~(op_a | op_b);
			ALU_SLT: result = {{(`DATA_W-1){1'b0}}, lt};
			// Shifts act on rt, not rs
			ALU_SLL: result = rd_data_b << shamt;
			ALU_SRL: result = rd_data_b >> shamt;
			ALU_LUI: result = issue.operand_b; // Pre-shifted by decoder
			default: result = '0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Writeback, lands at the end of the issue cycle
	////////////////////////////////////////////////////////////
	assign wr_en   = issue.valid; // Register file drops writes to 0
	assign wr_addr = issue.rd;
	assign wr_data = result;

	// Result strobe
	always_ff @(posedge clk) begin
		if (!rst_n)
			res_valid <= 1'b0;
		else
			res_valid <= issue.valid;
	end

	always_ff @(posedge clk) begin
		if (issue.valid) begin
			res_dest <= issue.rd;
			res_data <= result; // Reported even for register 0
		end
	end

endmodule

/* design/mips_core_top.sv */
`timescale 1ns/1ps
`include "mips_defines.svh"

module mips_core_top (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               instr_valid, // One word per strobe
	input  logic [`DATA_W-1:0] instr,
	input  logic [`REG_AW-1:0] dbg_addr,
	output logic               res_valid,   // Two edges after instr_valid
	output logic [`REG_AW-1:0] res_dest,
	output logic [`DATA_W-1:0] res_data,
	output logic [`DATA_W-1:0] dbg_data
);
	import mips_pkg::*;

	// Register file hookup
	reg_addr_t rd_addr_a;
	reg_addr_t rd_addr_b;
	word_t     rd_data_a;
	word_t     rd_data_b;
	logic      wr_en;
	reg_addr_t wr_addr;
	word_t     wr_data;

	mips_issue_if issue (); // Decoder to execute

	////////////////////////////////////////////////////////////
	// Blocks
	////////////////////////////////////////////////////////////
	instr_decoder i_decoder (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),     // Raw word onto the union
		.issue       (issue.producer)
	);

	register_file i_regfile (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd_addr_a (rd_addr_a),
		.rd_addr_b (rd_addr_b),
		.dbg_addr  (dbg_addr),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.dbg_data  (dbg_data),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data)
	);

	alu_execute i_execute (
		.clk       (clk),
		.rst_n     (rst_n),
		.issue     (issue.consumer),
		.rd_addr_a (rd_addr_a),
		.rd_addr_b (rd_addr_b),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.res_valid (res_valid),
		.res_dest  (res_dest),
		.res_data  (res_data)
	);

endmodule

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps

// Free running clock and power-on reset for the testbench
module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	// 100 ns period
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Low across four rising edges, released on a falling edge
	initial begin
		rst_n = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

/* testbench/tb_mips_core.sv */
`timescale 1ns/1ps
`include "mips_defines.svh"

module tb_mips_core;
	import mips_pkg::*;

	logic               clk;
	logic               rst_n;
	logic               instr_valid;
	logic [`DATA_W-1:0] instr;
	logic [`REG_AW-1:0] dbg_addr;
	logic               res_valid;
	logic [`REG_AW-1:0] res_dest;
	logic [`DATA_W-1:0] res_data;
	logic [`DATA_W-1:0] dbg_data;

	// Results in flight with the oldest first
	int        exp_due[$];  // Cycle count when res_valid must show
	reg_addr_t exp_dest[$];
	word_t     exp_data[$];
	string     exp_name[$];

	string trace_lines[$];  // Command lines only
	int    cycle_cnt   = 0; // Rising edges so far
	int    cycle_limit = 0; // Set once the trace is loaded

	tb_clock_gen i_clock_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	mips_core_top i_dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.dbg_addr    (dbg_addr),
		.res_valid   (res_valid),
		.res_dest    (res_dest),
		.res_data    (res_data),
		.dbg_data    (dbg_data)
	);

	////////////////////////////////////////////////////////////
	// Failure handling and compares
	////////////////////////////////////////////////////////////
	task automatic stop_on_failure();
		$display("Simulation failed");
		$fatal(1, "run stopped at cycle %0d", cycle_cnt);
	endtask

	task automatic report_failure(input string msg);
		$display("%s", msg);
		stop_on_failure();
	endtask

	task automatic check_result(input string name, input reg_addr_t exp_rd, input word_t exp_val,
			input reg_addr_t act_rd, input word_t act_val);
		if (exp_rd !== act_rd || exp_val !== act_val) begin
			$display("ERROR %s: expected r%0d=%h, actual r%0d=%h",
				name, exp_rd, exp_val, act_rd, act_val);
			stop_on_failure();
		end
	endtask

	task automatic check_reg(input string name, input word_t exp_val, input word_t act_val);
		if (exp_val !== act_val) begin
			$display("ERROR %s: expected %h, actual %h", name, exp_val, act_val);
			stop_on_failure();
		end
	endtask

	// Result monitor on the falling edge where outputs are settled
	task automatic watch_results();
		if (res_valid === 1'b1) begin
			if (exp_due.size() == 0)
				report_failure("Result strobe seen with no instruction in flight");
			else if (exp_due[0] != cycle_cnt)
				report_failure($sformatf("Result strobe at cycle %0d, due at cycle %0d",
					cycle_cnt, exp_due[0]));
			else begin
				check_result(exp_name[0], exp_dest[0], exp_data[0], res_dest, res_data);
				exp_due.delete(0);
				exp_dest.delete(0);
				exp_data.delete(0);
				exp_name.delete(0);
			end
		end else if (res_valid !== 1'b0) begin
			report_failure("res_valid is unknown");
		end else if (exp_due.size() != 0 && exp_due[0] <= cycle_cnt) begin
			report_failure({"Result strobe missing for ", exp_name[0]});
		end
	endtask

	task automatic next_cycle();
		@(negedge clk);
		watch_results();
	endtask

	////////////////////////////////////////////////////////////
	// Trace handling
	////////////////////////////////////////////////////////////
	task automatic load_trace();
		int    fd;
		int    code;
		string line;
		fd = $fopen("testbench/mips_trace.txt", "r");
		if (fd == 0)
			report_failure("Cannot open testbench/mips_trace.txt");
		while (!$feof(fd)) begin
			code = $fgets(line, fd);
			if (code == 0)
				break;
			if (line.len() > 1 && line.getc(0) != "#")
				trace_lines.push_back(line); // Skip blanks and comments
		end
		$fclose(fd);
	endtask

	// One command per call from a falling edge
	task automatic run_command(input string line);
		string              cmd;
		string              name;
		logic [`DATA_W-1:0] word_val;
		logic [`DATA_W-1:0] exp_val;
		int                 field;
		int                 n;
		n = $sscanf(line, "%s", cmd);
		next_cycle();
		instr_valid = 1'b0;
		if (cmd == "I") begin
			n = $sscanf(line, "%s %h %d %h %s", cmd, word_val, field, exp_val, name);
			if (n != 5)
				report_failure({"Malformed trace line: ", line});
			instr_valid = 1'b1;
			instr       = word_val;
			exp_due.push_back(cycle_cnt + 2); // Sampled next edge and reported one edge later
			exp_dest.push_back(reg_addr_t'(field));
			exp_data.push_back(exp_val);
			exp_name.push_back(name);
		end else if (cmd == "N") begin
			n = $sscanf(line, "%s %h %s", cmd, word_val, name);
			if (n != 3)
				report_failure({"Malformed trace line: ", line});
			instr_valid = 1'b1; // Word must be dropped
			instr       = word_val;
		end else if (cmd == "D") begin
			n = $sscanf(line, "%s %d %h %s", cmd, field, exp_val, name);
			if (n != 4)
				report_failure({"Malformed trace line: ", line});
			dbg_addr = reg_addr_t'(field);
			#10; // Combinational read settles
			check_reg(name, exp_val, dbg_data);
		end else if (cmd == "W") begin
			n = $sscanf(line, "%s %d", cmd, field);
			if (n != 2 || field < 1)
				report_failure({"Malformed trace line: ", line});
			repeat (field - 1) next_cycle();
		end else begin
			report_failure({"Unknown trace command: ", line});
		end
	endtask

	// Whole register file zero after reset
	task automatic check_reset_state();
		for (int a = 0; a < 2**`REG_AW; a++) begin
			next_cycle(); // One register per falling edge
			dbg_addr = reg_addr_t'(a);
			#10;
			check_reg($sformatf("reset_r%0d", a), '0, dbg_data);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence and timeout
	////////////////////////////////////////////////////////////
	initial begin
		instr_valid = 1'b0;
		instr       = '0;
		dbg_addr    = '0;
		load_trace();
		cycle_limit = 4 * trace_lines.size() + 20; // Most lines take one cycle
		wait (rst_n === 1'b1);
		check_reset_state();
		foreach (trace_lines[i])
			run_command(trace_lines[i]);
		// Let the last results come out
		repeat (3) begin
			next_cycle();
			instr_valid = 1'b0;
		end
		if (exp_due.size() == 0) begin
			$display("Simulation passed");
			$finish;
		end else begin
			report_failure("Results still outstanding after the trace ended");
		end
	end

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
			report_failure($sformatf("Timeout after %0d cycles, the testbench hung", cycle_cnt));
	end

endmodule

/* testbench/mips_trace.txt */
# I word dest data name | N word name (no result) | D reg value name
# W cycles name (idle). Words, data and values in hex, dest, reg and cycles in decimal
I 34010005 1 00000005 ori_r1_5
I 2002FFFD 2 FFFFFFFD addi_r2_neg3
I 3C031234 3 12340000 lui_r3
I 3463ABCD 3 1234ABCD ori_r3_dep
W 2 settle_a
D 3 1234ABCD dbg_r3_after_dep
I 00222020 4 00000002 add_r4
I 00222822 5 00000008 sub_r5
I 0041302A 6 00000001 slt_neg_less
I 0022382A 7 00000000 slt_pos_not_less
I 00614024 8 00000005 and_r8
I 00244825 9 00000007 or_r9
I 00625026 10 EDCB5430 xor_r10
I 00245827 11 FFFFFFF8 nor_r11
I 00016100 12 00000050 sll_by_4
I 00036A02 13 001234AB srl_by_8
I 000277C2 14 00000001 srl_by_31
W 1 gap_a
I 284FFFFE 15 00000001 slti_neg_imm
I 3050FFF0 16 0000FFF0 andi_zero_ext
I 34118000 17 00008000 ori_zero_ext
I 3872FFFF 18 12345432 xori_r18
I 2014000A 20 0000000A addi_r20
I 0294A020 20 00000014 add_r20_dep
I 0281A822 21 0000000F sub_r21_dep
I 22B5FFF0 21 FFFFFFFF addi_r21_dep
I 20200007 0 0000000C addi_to_r0
N 8C050000 lw_dropped
N 00223018 mult_dropped
W 2 settle_b
D 0 00000000 dbg_r0_zero
D 1 00000005 dbg_r1
D 2 FFFFFFFD dbg_r2
D 5 00000008 dbg_r5_unchanged
D 6 00000001 dbg_r6_unchanged
D 13 001234AB dbg_r13
D 17 00008000 dbg_r17
D 20 00000014 dbg_r20
D 21 FFFFFFFF dbg_r21
D 31 00000000 dbg_r31

/* all.f */
+incdir+include
design/mips_pkg.sv
design/mips_issue_if.sv
design/instr_decoder.sv
design/register_file.sv
design/alu_execute.sv
design/mips_core_top.sv
testbench/tb_clock_gen.sv
testbench/tb_mips_core.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the MIPS execute testbench with Verilator.
# A failing check ends in $fatal, which gives a nonzero exit status.
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
	-f all.f \
	--top-module tb_mips_core \
	-o tb_mips_core_sim

./obj_dir/tb_mips_core_sim
